// ==== Makefile ====
# Verilator build and run of the NIC testbench

TOP      ?= nic_tb
SEED     ?= 28017
VFLAGS   ?= --binary --timing --assert -Wno-fatal
SIMFLAGS ?= +verilator+error+limit+100
FLIST    := all.f
SRCS     := $(shell cat $(FLIST))
BIN      := obj_dir/V$(TOP)
LOG      := sim.log

.PHONY: all build run clean

all: run

build: $(BIN)

obj_dir/V%: $(SRCS) $(FLIST)
	verilator $(VFLAGS) --top-module $* -GSEED=$(SEED) -f $(FLIST)

run: $(BIN)
	@./$(BIN) $(SIMFLAGS) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
logic/nic_pkg.sv
logic/nic_ifs.sv
logic/nic_regs.sv
logic/irq_ctrl.sv
logic/tx_ring_fetch.sv
logic/rx_ring_store.sv
logic/dma_arbiter.sv
logic/nic_top.sv
bench/nic_props.sv
bench/nic_tb.sv

// ==== bench/nic_props.sv ====
`timescale 1ns/1ps

module nic_props import nic_pkg::*; (
	input logic aclk,
	input logic arst_n_i,
	input logic reg_rd_i,
	input logic reg_rvalid_o,
	input logic mem_req_o,
	input logic mem_we_o,
	input mem_addr_t mem_addr_o,
	input word_t mem_wdata_o,
	input logic mem_gnt_i,
	input logic intr_o
);

	int unsigned fail_count = 0;

	// Waiting request holds until granted
	req_held: assert property (@(posedge aclk) disable iff (!arst_n_i)
		mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) &&
			$stable(mem_addr_o) && $stable(mem_wdata_o))
	else begin
		$error("host request changed before its grant");
		fail_count++;
	end

	intr_low_after_reset: assert property (@(posedge aclk) $rose(arst_n_i) |=> !intr_o)
	else begin
		$error("intr_o high right after reset release");
		fail_count++;
	end

	rvalid_after_rd: assert property (@(posedge aclk) disable iff (!arst_n_i)
		reg_rd_i |=> reg_rvalid_o)
	else begin
		$error("reg_rvalid_o missing one cycle after reg_rd_i");
		fail_count++;
	end

	rvalid_only_after_rd: assert property (@(posedge aclk) disable iff (!arst_n_i)
		!reg_rd_i |=> !reg_rvalid_o)
	else begin
		$error("reg_rvalid_o without a read");
		fail_count++;
	end

endmodule

bind nic_top nic_props u_props (
	.aclk(aclk),
	.arst_n_i(arst_n_i),
	.reg_rd_i(reg_rd_i),
	.reg_rvalid_o(reg_rvalid_o),
	.mem_req_o(mem_req_o),
	.mem_we_o(mem_we_o),
	.mem_addr_o(mem_addr_o),
	.mem_wdata_o(mem_wdata_o),
	.mem_gnt_i(mem_gnt_i),
	.intr_o(intr_o)
);

// ==== bench/nic_tb.sv ====
`timescale 1ns/1ps

module nic_tb import nic_pkg::*; #(
	parameter int unsigned SEED = 32'h6d71
);

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_CYCLES = 20000; // Five tests of a few hundred cycles each
	localparam int READ_LAT = 2;
	localparam int MEM_WORDS = 256;
	localparam int SLOT = 4;
	localparam word_t EN_VAL = word_t'(1 << EN_BIT);

	logic aclk;
	logic arst_n_i;
	logic reg_wr_i;
	logic reg_rd_i;
	reg_addr_t reg_addr_i;
	word_t reg_wdata_i;
	word_t reg_rdata_o;
	logic reg_rvalid_o;
	logic mem_req_o;
	logic mem_we_o;
	mem_addr_t mem_addr_o;
	word_t mem_wdata_o;
	logic mem_gnt_i = 1'b0;
	logic mem_rvalid_i = 1'b0;
	word_t mem_rdata_i = '0;
	word_t tx_data_o;
	logic tx_valid_o;
	word_t rx_data_i;
	logic rx_valid_i;
	logic intr_o;

	int checks = 0;
	int errors = 0;
	int cycle_count = 0;
	int unsigned max_gnt_delay;

	word_t mem [MEM_WORDS];
	mem_addr_t wr_addr_q [$];
	word_t wr_data_q [$];
	word_t tx_seen_q [$];
	int gnt_wait = -1;
	int rd_wait = 0;
	word_t rd_word = '0;

	nic_top #(.SLOT_BYTES(SLOT)) u_dut (
		.aclk(aclk),
		.arst_n_i(arst_n_i),
		.reg_wr_i(reg_wr_i),
		.reg_rd_i(reg_rd_i),
		.reg_addr_i(reg_addr_i),
		.reg_wdata_i(reg_wdata_i),
		.reg_rdata_o(reg_rdata_o),
		.reg_rvalid_o(reg_rvalid_o),
		.mem_req_o(mem_req_o),
		.mem_we_o(mem_we_o),
		.mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o),
		.mem_gnt_i(mem_gnt_i),
		.mem_rvalid_i(mem_rvalid_i),
		.mem_rdata_i(mem_rdata_i),
		.tx_data_o(tx_data_o),
		.tx_valid_o(tx_valid_o),
		.rx_data_i(rx_data_i),
		.rx_valid_i(rx_valid_i),
		.intr_o(intr_o)
	);

	initial begin
		aclk = 1'b0;
		forever #(CLK_PERIOD / 2) aclk = ~aclk;
	end

	always @(posedge aclk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	function automatic word_t fill_word(input mem_addr_t addr);
		return {8'hD0, addr[9:2], 8'h3C, ~addr[9:2]};
	endfunction

	function automatic word_t rx_word(input int k);
		return 32'h5EED_0000 | word_t'(k);
	endfunction

	// Host memory grants after a random delay and returns reads READ_LAT cycles later
	always @(posedge aclk) begin
		mem_rvalid_i <= 1'b0;
		if (!arst_n_i) begin
			mem_gnt_i <= 1'b0;
			gnt_wait = -1;
			rd_wait = 0;
			wr_addr_q.delete();
			wr_data_q.delete();
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] = fill_word(mem_addr_t'(i * 4));
		end else begin
			if (rd_wait > 0) begin
				rd_wait--;
				if (rd_wait == 0) begin
					mem_rvalid_i <= 1'b1;
					mem_rdata_i <= rd_word;
				end
			end
			if (mem_gnt_i && mem_req_o) begin
				mem_gnt_i <= 1'b0; // Transfer cycle
				gnt_wait = -1;
				if (mem_we_o) begin
					mem[mem_addr_o[9:2]] = mem_wdata_o;
					wr_addr_q.push_back(mem_addr_o);
					wr_data_q.push_back(mem_wdata_o);
				end else begin
					rd_word = mem[mem_addr_o[9:2]];
					rd_wait = READ_LAT - 1;
				end
			end else if (mem_req_o) begin
				if (gnt_wait < 0)
					gnt_wait = int'($urandom_range(max_gnt_delay));
				if (gnt_wait == 0)
					mem_gnt_i <= 1'b1;
				else
					gnt_wait--;
			end
		end
	end

	always @(posedge aclk) begin
		if (!arst_n_i)
			tx_seen_q.delete();
		else if (tx_valid_o)
			tx_seen_q.push_back(tx_data_o);
	end

	task automatic apply_reset();
		@(posedge aclk);
		arst_n_i <= 1'b0;
		repeat (RESET_CYCLES) @(posedge aclk);
		arst_n_i <= 1'b1;
	endtask

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH %s: expected 0x%08h, got 0x%08h", name, exp, got);
			errors++;
		end
	endtask

	task automatic reg_write(input reg_addr_t addr, input word_t data);
		@(posedge aclk);
		reg_wr_i <= 1'b1;
		reg_addr_i <= addr;
		reg_wdata_i <= data;
		@(posedge aclk);
		reg_wr_i <= 1'b0;
	endtask

	task automatic reg_read(input reg_addr_t addr, output word_t data);
		@(posedge aclk);
		reg_rd_i <= 1'b1;
		reg_addr_i <= addr;
		@(posedge aclk);
		reg_rd_i <= 1'b0;
		@(negedge aclk);
		if (reg_rvalid_o !== 1'b1) begin
			$display("Read of register 0x%04h got no reg_rvalid_o", addr);
			errors++;
		end
		data = reg_rdata_o;
	endtask

	task automatic expect_reg(input reg_addr_t addr, input word_t exp);
		word_t data;
		reg_read(addr, data);
		compare_word($sformatf("reg_rdata_o[0x%04h]", addr), data, exp);
	endtask

	task automatic send_rx(input word_t data);
		@(posedge aclk);
		rx_valid_i <= 1'b1;
		rx_data_i <= data;
		@(posedge aclk);
		rx_valid_i <= 1'b0;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) @(posedge aclk);
	endtask

	task automatic wait_tx(input int count, input int budget);
		int n;
		n = 0;
		while (tx_seen_q.size() < count && n < budget) begin
			@(negedge aclk);
			n++;
		end
		if (tx_seen_q.size() < count) begin
			$display("Transmit stream stalled at %0d of %0d words", tx_seen_q.size(), count);
			errors++;
		end
	endtask

	task automatic wait_writes(input int count, input int budget);
		int n;
		n = 0;
		while (wr_addr_q.size() < count && n < budget) begin
			@(negedge aclk);
			n++;
		end
		if (wr_addr_q.size() < count) begin
			$display("Memory saw %0d of %0d receive writes", wr_addr_q.size(), count);
			errors++;
		end
	endtask

	task automatic wait_intr(input logic level, input int budget);
		int n;
		n = 0;
		@(negedge aclk);
		while (intr_o !== level && n < budget) begin
			@(negedge aclk);
			n++;
		end
		compare_word("intr_o", word_t'(intr_o), word_t'(level));
	endtask

	task automatic reset_readback();
		reg_addr_t all_ofs [14] = '{ICR_OFS, ICS_OFS, IMS_OFS, IMC_OFS, RCTL_OFS, TCTL_OFS,
			RDBA_OFS, RDLEN_OFS, RDH_OFS, RDT_OFS, TDBA_OFS, TDLEN_OFS, TDH_OFS, TDT_OFS};
		reg_addr_t rw_ofs [9] = '{TDBA_OFS, RDBA_OFS, TDLEN_OFS, RDLEN_OFS, TDT_OFS,
			RDT_OFS, IMS_OFS, TCTL_OFS, RCTL_OFS};
		// Control values keep the enable bit clear
		word_t rw_val [9] = '{32'h1234_5670, 32'h89AB_CDE0, 32'h0000_0040, 32'h0000_0080,
			32'h0000_0011, 32'h0000_0022, 32'h0000_00C1, 32'h5A5A_0005, 32'hA5A5_0008};
		apply_reset();
		@(negedge aclk);
		compare_word("intr_o", word_t'(intr_o), '0);
		foreach (all_ofs[i])
			expect_reg(all_ofs[i], '0);
		foreach (rw_ofs[i])
			reg_write(rw_ofs[i], rw_val[i]);
		foreach (rw_ofs[i])
			expect_reg(rw_ofs[i], rw_val[i]);
		@(negedge aclk);
		compare_word("intr_o", word_t'(intr_o), '0);
	endtask

	task automatic tx_fetch_to_tail();
		mem_addr_t base;
		base = 32'h0000_0040;
		apply_reset();
		reg_write(TDBA_OFS, base);
		reg_write(TDLEN_OFS, 32'd4);
		reg_write(TCTL_OFS, EN_VAL);
		reg_write(TDT_OFS, 32'd3);
		wait_tx(3, 200);
		idle(20); // Nothing beyond the tail
		compare_word("tx_valid_o pulses", word_t'(tx_seen_q.size()), 32'd3);
		foreach (tx_seen_q[i])
			compare_word("tx_data_o", tx_seen_q[i], fill_word(base + mem_addr_t'(i * SLOT)));
		expect_reg(TDH_OFS, 32'd3);
		expect_reg(ICR_OFS, word_t'(1 << TXDW_BIT));
	endtask

	task automatic rx_store_overrun();
		mem_addr_t base;
		base = 32'h0000_0200;
		apply_reset();
		reg_write(RDBA_OFS, base);
		reg_write(RDLEN_OFS, 32'd4);
		reg_write(RDT_OFS, 32'd2);
		reg_write(RCTL_OFS, EN_VAL);
		for (int k = 0; k < 3; k++) begin
			send_rx(rx_word(k));
			if (k < 2)
				wait_writes(k + 1, 100);
			else
				idle(20); // Third word has no free slot
		end
		compare_word("receive writes", word_t'(wr_addr_q.size()), 32'd2);
		foreach (wr_addr_q[k]) begin
			compare_word("mem_addr_o", wr_addr_q[k], base + mem_addr_t'(k * SLOT));
			compare_word("mem_wdata_o", wr_data_q[k], rx_word(k));
		end
		expect_reg(RDH_OFS, 32'd2);
		expect_reg(ICR_OFS, word_t'((1 << RXT0_BIT) | (1 << RXO_BIT)));
	endtask

	task automatic intr_masking();
		apply_reset();
		reg_write(IMS_OFS, word_t'(1 << RXT0_BIT));
		reg_write(ICS_OFS, word_t'((1 << TXDW_BIT) | (1 << RXO_BIT)));
		idle(4);
		@(negedge aclk);
		compare_word("intr_o", word_t'(intr_o), '0); // Causes not enabled
		reg_write(ICS_OFS, word_t'(1 << RXT0_BIT));
		wait_intr(1'b1, 6);
		reg_write(IMC_OFS, word_t'(1 << RXT0_BIT));
		wait_intr(1'b0, 6);
		expect_reg(IMS_OFS, '0);
		reg_write(IMS_OFS, word_t'(1 << TXDW_BIT));
		wait_intr(1'b1, 6);
		expect_reg(ICR_OFS, 32'h0000_00C1);
		wait_intr(1'b0, 6);
		expect_reg(ICR_OFS, '0);
		expect_reg(IMS_OFS, word_t'(1 << TXDW_BIT));
	endtask

	task automatic concurrent_wrap();
		mem_addr_t tx_base, rx_base;
		int tx_len, rx_len;
		tx_base = 32'h0000_0000;
		rx_base = 32'h0000_0300;
		tx_len = 5;
		rx_len = 6;
		apply_reset();
		max_gnt_delay = 5;
		reg_write(TDBA_OFS, tx_base);
		reg_write(TDLEN_OFS, word_t'(tx_len));
		reg_write(RDBA_OFS, rx_base);
		reg_write(RDLEN_OFS, word_t'(rx_len));
		reg_write(TDT_OFS, 32'd3);
		reg_write(RDT_OFS, 32'd4);
		reg_write(TCTL_OFS, EN_VAL);
		reg_write(RCTL_OFS, EN_VAL);
		for (int k = 0; k < 4; k++) begin
			send_rx(rx_word(k));
			wait_writes(k + 1, 200);
		end
		wait_tx(3, 400);
		// Second pass crosses the end of both rings
		reg_write(TDT_OFS, 32'd1);
		reg_write(RDT_OFS, 32'd2);
		for (int k = 4; k < 8; k++) begin
			send_rx(rx_word(k));
			wait_writes(k + 1, 200);
		end
		wait_tx(6, 400);
		compare_word("tx_valid_o pulses", word_t'(tx_seen_q.size()), 32'd6);
		foreach (tx_seen_q[i])
			compare_word("tx_data_o", tx_seen_q[i],
				fill_word(tx_base + mem_addr_t'((i % tx_len) * SLOT)));
		compare_word("receive writes", word_t'(wr_addr_q.size()), 32'd8);
		foreach (wr_addr_q[k]) begin
			compare_word("mem_addr_o", wr_addr_q[k], rx_base + mem_addr_t'((k % rx_len) * SLOT));
			compare_word("mem_wdata_o", wr_data_q[k], rx_word(k));
		end
		expect_reg(TDH_OFS, 32'd1);
		expect_reg(RDH_OFS, 32'd2);
	endtask

	initial begin
		arst_n_i = 1'b0;
		reg_wr_i = 1'b0;
		reg_rd_i = 1'b0;
		reg_addr_i = '0;
		reg_wdata_i = '0;
		rx_data_i = '0;
		rx_valid_i = 1'b0;
		max_gnt_delay = 3;
		void'($urandom(SEED));
		reset_readback();
		tx_fetch_to_tail();
		rx_store_overrun();
		intr_masking();
		concurrent_wrap();
		idle(2);
		errors += int'(u_dut.u_props.fail_count); // Bound assertion failures
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== logic/dma_arbiter.sv ====
`timescale 1ns/1ps

module dma_arbiter import nic_pkg::*; (
	input logic aclk,
	input logic arst_n_i,
	host_mem_if.arbiter tx_m,
	host_mem_if.arbiter rx_m,
	output logic mem_req_o,
	output logic mem_we_o,
	output mem_addr_t mem_addr_o,
	output word_t mem_wdata_o,
	input logic mem_gnt_i,
	input logic mem_rvalid_i,
	input word_t mem_rdata_i
);

	logic prio_rx_q; // Receive side wins the next tie
	logic hold_q, hold_rx_q;
	logic sel_rx;

	// A waiting request keeps its slot until granted
	always_comb begin
		if (hold_q)
			sel_rx = hold_rx_q;
		else
			sel_rx = rx_m.req && (!tx_m.req || prio_rx_q);
	end

	assign mem_req_o = tx_m.req || rx_m.req;
	assign mem_we_o = sel_rx ? rx_m.we : tx_m.we;
	assign mem_addr_o = sel_rx ? rx_m.addr : tx_m.addr;
	assign mem_wdata_o = sel_rx ? rx_m.wdata : tx_m.wdata;

	assign tx_m.gnt = mem_gnt_i && !sel_rx && tx_m.req;
	assign rx_m.gnt = mem_gnt_i && sel_rx;

	// Only transmit reads
	assign tx_m.rvalid = mem_rvalid_i;
	assign tx_m.rdata = mem_rdata_i;
	assign rx_m.rvalid = 1'b0;
	assign rx_m.rdata = '0;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			prio_rx_q <= 1'b0;
			hold_q <= 1'b0;
			hold_rx_q <= 1'b0;
		end else begin
			hold_q <= mem_req_o && !mem_gnt_i;
			hold_rx_q <= sel_rx;
			if (mem_req_o && mem_gnt_i)
				prio_rx_q <= !sel_rx;
		end
	end

endmodule

// ==== logic/irq_ctrl.sv ====
`timescale 1ns/1ps

module irq_ctrl import nic_pkg::*; (
	input logic aclk,
	input logic arst_n_i,
	irq_cfg_if.ctrl irq,
	input cause_t cause_i,
	output logic intr_o
);

	cause_t icr_q, ims_q;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			icr_q <= '0;
			ims_q <= '0;
			intr_o <= 1'b0;
		end else begin
			// New causes win over the read clear
			icr_q <= (irq.icr_rd ? '0 : icr_q) | cause_i | (irq.ics_wr ? irq.wdata : '0);
			if (irq.ims_wr)
				ims_q <= ims_q | irq.wdata;
			else if (irq.imc_wr)
				ims_q <= ims_q & ~irq.wdata;
			intr_o <= |(icr_q & ims_q);
		end
	end

	assign irq.icr = icr_q;
	assign irq.ims = ims_q;

endmodule

// ==== logic/nic_ifs.sv ====
`timescale 1ns/1ps

// One per descriptor ring
interface ring_cfg_if import nic_pkg::*; ();
	mem_addr_t base;
	ring_idx_t len;
	ring_idx_t tail;
	logic en;
	ring_idx_t head;

	modport regs (output base, len, tail, en, input head);
	modport engine (input base, len, tail, en, output head);
endinterface

interface irq_cfg_if import nic_pkg::*; ();
	word_t wdata;
	logic ics_wr;
	logic ims_wr;
	logic imc_wr;
	logic icr_rd;
	cause_t icr;
	cause_t ims;

	modport regs (output wdata, ics_wr, ims_wr, imc_wr, icr_rd, input icr, ims);
	modport ctrl (input wdata, ics_wr, ims_wr, imc_wr, icr_rd, output icr, ims);
endinterface

// Single beat, request held until gnt
interface host_mem_if import nic_pkg::*; ();
	logic req;
	logic we;
	mem_addr_t addr;
	word_t wdata;
	logic gnt;
	logic rvalid;
	word_t rdata;

	modport requester (output req, we, addr, wdata, input gnt, rvalid, rdata);
	modport arbiter (input req, we, addr, wdata, output gnt, rvalid, rdata);
endinterface

// ==== logic/nic_pkg.sv ====
package nic_pkg;

	typedef logic [15:0] reg_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [31:0] mem_addr_t;
	typedef logic [15:0] ring_idx_t;
	typedef logic [31:0] cause_t;

	// Interrupt registers
	localparam reg_addr_t ICR_OFS   = 16'h00C0;
	localparam reg_addr_t ICS_OFS   = 16'h00C8;
	localparam reg_addr_t IMS_OFS   = 16'h00D0;
	localparam reg_addr_t IMC_OFS   = 16'h00D8;

	localparam reg_addr_t RCTL_OFS  = 16'h0100;
	localparam reg_addr_t TCTL_OFS  = 16'h0400;

	localparam reg_addr_t RDBA_OFS  = 16'h2800;
	localparam reg_addr_t RDLEN_OFS = 16'h2808;
	localparam reg_addr_t RDH_OFS   = 16'h2810;
	localparam reg_addr_t RDT_OFS   = 16'h2818;
	localparam reg_addr_t TDBA_OFS  = 16'h3800;
	localparam reg_addr_t TDLEN_OFS = 16'h3808;
	localparam reg_addr_t TDH_OFS   = 16'h3810;
	localparam reg_addr_t TDT_OFS   = 16'h3818;

	localparam int EN_BIT   = 1; // RCTL/TCTL enable
	localparam int TXDW_BIT = 0;
	localparam int RXO_BIT  = 6;
	localparam int RXT0_BIT = 7;

endpackage

// ==== logic/nic_regs.sv ====
`timescale 1ns/1ps

module nic_regs import nic_pkg::*; (
	input logic aclk,
	input logic arst_n_i,
	input logic reg_wr_i,
	input logic reg_rd_i,
	input reg_addr_t reg_addr_i,
	input word_t reg_wdata_i,
	output word_t reg_rdata_o,
	output logic reg_rvalid_o,
	ring_cfg_if.regs tx_cfg,
	ring_cfg_if.regs rx_cfg,
	irq_cfg_if.regs irq
);

	word_t tctl, rctl;
	mem_addr_t tdba, rdba;
	ring_idx_t tdlen, rdlen, tdt, rdt;
	word_t rd_mux;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tctl <= '0;
			rctl <= '0;
			tdba <= '0;
			rdba <= '0;
			tdlen <= '0;
			rdlen <= '0;
			tdt <= '0;
			rdt <= '0;
		end else if (reg_wr_i) begin
			case (reg_addr_i)
				TCTL_OFS: tctl <= reg_wdata_i;
				RCTL_OFS: rctl <= reg_wdata_i;
				TDBA_OFS: tdba <= reg_wdata_i;
				RDBA_OFS: rdba <= reg_wdata_i;
				TDLEN_OFS: tdlen <= reg_wdata_i[15:0];
				RDLEN_OFS: rdlen <= reg_wdata_i[15:0];
				TDT_OFS: tdt <= reg_wdata_i[15:0];
				RDT_OFS: rdt <= reg_wdata_i[15:0];
				default: ; // Heads are read-only
			endcase
		end
	end

	// Interrupt accesses go out as strobes
	assign irq.wdata = reg_wdata_i;
	assign irq.ics_wr = reg_wr_i && (reg_addr_i == ICS_OFS);
	assign irq.ims_wr = reg_wr_i && (reg_addr_i == IMS_OFS);
	assign irq.imc_wr = reg_wr_i && (reg_addr_i == IMC_OFS);
	assign irq.icr_rd = reg_rd_i && (reg_addr_i == ICR_OFS);

	assign tx_cfg.base = tdba;
	assign tx_cfg.len = tdlen;
	assign tx_cfg.tail = tdt;
	assign tx_cfg.en = tctl[EN_BIT];
	assign rx_cfg.base = rdba;
	assign rx_cfg.len = rdlen;
	assign rx_cfg.tail = rdt;
	assign rx_cfg.en = rctl[EN_BIT];

	always_comb begin
		case (reg_addr_i)
			ICR_OFS: rd_mux = irq.icr; // Value before the clear
			IMS_OFS: rd_mux = irq.ims;
			TCTL_OFS: rd_mux = tctl;
			RCTL_OFS: rd_mux = rctl;
			TDBA_OFS: rd_mux = tdba;
			RDBA_OFS: rd_mux = rdba;
			TDLEN_OFS: rd_mux = word_t'(tdlen);
			RDLEN_OFS: rd_mux = word_t'(rdlen);
			TDH_OFS: rd_mux = word_t'(tx_cfg.head);
			RDH_OFS: rd_mux = word_t'(rx_cfg.head);
			TDT_OFS: rd_mux = word_t'(tdt);
			RDT_OFS: rd_mux = word_t'(rdt);
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			reg_rvalid_o <= 1'b0;
			reg_rdata_o <= '0;
		end else begin
			reg_rvalid_o <= reg_rd_i;
			if (reg_rd_i)
				reg_rdata_o <= rd_mux;
		end
	end

endmodule

// ==== logic/nic_top.sv ====
`timescale 1ns/1ps

module nic_top import nic_pkg::*; #(
	parameter int SLOT_BYTES = 4
) (
	input logic aclk,
	input logic arst_n_i,
	input logic reg_wr_i,
	input logic reg_rd_i,
	input reg_addr_t reg_addr_i,
	input word_t reg_wdata_i,
	output word_t reg_rdata_o,
	output logic reg_rvalid_o,
	output logic mem_req_o,
	output logic mem_we_o,
	output mem_addr_t mem_addr_o,
	output word_t mem_wdata_o,
	input logic mem_gnt_i,
	input logic mem_rvalid_i,
	input word_t mem_rdata_i,
	output word_t tx_data_o,
	output logic tx_valid_o,
	input word_t rx_data_i,
	input logic rx_valid_i,
	output logic intr_o
);

	ring_cfg_if tx_cfg ();
	ring_cfg_if rx_cfg ();
	irq_cfg_if irq ();
	host_mem_if tx_mem ();
	host_mem_if rx_mem ();

	logic txdw, rxt0, rxo;
	cause_t cause;

	always_comb begin
		cause = '0;
		cause[TXDW_BIT] = txdw;
		cause[RXO_BIT] = rxo;
		cause[RXT0_BIT] = rxt0;
	end

	nic_regs regs_i (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.reg_wr_i(reg_wr_i), .reg_rd_i(reg_rd_i),
		.reg_addr_i(reg_addr_i), .reg_wdata_i(reg_wdata_i),
		.reg_rdata_o(reg_rdata_o), .reg_rvalid_o(reg_rvalid_o),
		.tx_cfg(tx_cfg), .rx_cfg(rx_cfg), .irq(irq)
	);

	irq_ctrl irq_i (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.irq(irq), .cause_i(cause), .intr_o(intr_o)
	);

	tx_ring_fetch #(.SLOT_BYTES(SLOT_BYTES)) tx_i (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.cfg(tx_cfg), .mem(tx_mem),
		.tx_data_o(tx_data_o), .tx_valid_o(tx_valid_o), .txdw_o(txdw)
	);

	rx_ring_store #(.SLOT_BYTES(SLOT_BYTES)) rx_i (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.cfg(rx_cfg), .mem(rx_mem),
		.rx_data_i(rx_data_i), .rx_valid_i(rx_valid_i),
		.rxt0_o(rxt0), .rxo_o(rxo)
	);

	dma_arbiter arb_i (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.tx_m(tx_mem), .rx_m(rx_mem),
		.mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
		.mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
		.mem_gnt_i(mem_gnt_i), .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i)
	);

endmodule

// ==== logic/rx_ring_store.sv ====
`timescale 1ns/1ps

module rx_ring_store import nic_pkg::*; #(
	parameter int SLOT_BYTES = 4
) (
	input logic aclk,
	input logic arst_n_i,
	ring_cfg_if.engine cfg,
	host_mem_if.requester mem,
	input word_t rx_data_i,
	input logic rx_valid_i,
	output logic rxt0_o,
	output logic rxo_o
);

	logic full_q, accept, done;
	word_t buf_q;
	ring_idx_t head_q, head_inc;

	// Free slot exists while head has not reached tail
	assign accept = rx_valid_i && !full_q && cfg.en && (head_q != cfg.tail);
	assign done = full_q && mem.gnt;
	assign head_inc = head_q + 1'b1;

	assign mem.req = full_q;
	assign mem.we = 1'b1;
	assign mem.addr = cfg.base + mem_addr_t'(head_q) * mem_addr_t'(SLOT_BYTES);
	assign mem.wdata = buf_q;
	assign cfg.head = head_q;

	assign rxt0_o = done;
	assign rxo_o = rx_valid_i && !accept; // Dropped word

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			full_q <= 1'b0;
			head_q <= '0;
		end else begin
			if (accept)
				full_q <= 1'b1;
			else if (done)
				full_q <= 1'b0;
			if (done)
				head_q <= (head_inc >= cfg.len) ? '0 : head_inc;
		end
	end

	always_ff @(posedge aclk) begin
		if (accept)
			buf_q <= rx_data_i;
	end

endmodule

// ==== logic/tx_ring_fetch.sv ====
`timescale 1ns/1ps

module tx_ring_fetch import nic_pkg::*; #(
	parameter int SLOT_BYTES = 4
) (
	input logic aclk,
	input logic arst_n_i,
	ring_cfg_if.engine cfg,
	host_mem_if.requester mem,
	output word_t tx_data_o,
	output logic tx_valid_o,
	output logic txdw_o
);

	typedef enum logic [1:0] {IDLE, REQ, WAIT} state_t;

	state_t state;
	ring_idx_t head_q, head_inc, head_nxt;

	assign head_inc = head_q + 1'b1;
	assign head_nxt = (head_inc >= cfg.len) ? '0 : head_inc; // Wrap at len

	assign mem.req = (state == REQ);
	assign mem.we = 1'b0;
	assign mem.addr = cfg.base + mem_addr_t'(head_q) * mem_addr_t'(SLOT_BYTES);
	assign mem.wdata = '0;
	assign cfg.head = head_q;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= IDLE;
			head_q <= '0;
			tx_valid_o <= 1'b0;
			txdw_o <= 1'b0;
		end else begin
			tx_valid_o <= 1'b0;
			txdw_o <= 1'b0;
			case (state)
				IDLE: if (cfg.en && head_q != cfg.tail) state <= REQ;
				REQ: if (mem.gnt) state <= WAIT;
				WAIT: if (mem.rvalid) begin
					state <= IDLE;
					head_q <= head_nxt;
					tx_valid_o <= 1'b1;
					txdw_o <= (head_nxt == cfg.tail); // Ring drained
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (state == WAIT && mem.rvalid)
			tx_data_o <= mem.rdata;
	end

endmodule
